/* include/sar_cfg.svh */
`ifndef SAR_CFG_SVH
`define SAR_CFG_SVH

// ----------------------------------------------------------
// Segmentation engine configuration
// ----------------------------------------------------------

// Frame buffers addressable by a descriptor
`define SAR_NUM_BUFFERS 16

// Largest frame in bytes
`define SAR_MAX_FRAME_SIZE 4096

// Segment length limits in bytes
`define SAR_MAX_SEG_LEN 1024
`define SAR_DEFAULT_SEG_LEN 64

// Frame descriptors waiting ahead of the segmenter
`define SAR_FIFO_DEPTH 4

`endif

/* hw/sar_types_pkg.sv */
`include "sar_cfg.svh"

package sar_types_pkg;

    // ----------------------------------------------------------
    // Data-path widths
    // ----------------------------------------------------------

    // Buffer index
    typedef logic [$clog2(`SAR_NUM_BUFFERS)-1:0] buf_id_t;

    // Frame length, 0 up to and including the maximum frame size
    typedef logic [$clog2(`SAR_MAX_FRAME_SIZE+1)-1:0] frame_len_t;

    // Byte offset inside a frame
    typedef logic [$clog2(`SAR_MAX_FRAME_SIZE)-1:0] offset_t;

    // Segment length, 0 up to and including the maximum segment length
    typedef logic [$clog2(`SAR_MAX_SEG_LEN+1)-1:0] seg_len_t;

endpackage : sar_types_pkg

/* hw/sar_regs_pkg.sv */
package sar_regs_pkg;

    typedef logic [2:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // Register map
    typedef enum logic [2:0] {
        CONTROL     = 3'd0,
        CONFIG      = 3'd1,
        STATUS      = 3'd2,
        INFO        = 3'd3,
        FRAME_COUNT = 3'd4,
        SEG_COUNT   = 3'd5
    } reg_addr_e;

    // STATUS layout
    typedef struct packed {
        logic [29:0] rsvd;
        logic        init_done;
        logic        blk_srst;
    } status_reg_t;

    // INFO layout
    typedef struct packed {
        logic [15:0] max_seg_len;
        logic [7:0]  rsvd;
        logic [7:0]  num_buffers;
    } info_reg_t;

endpackage : sar_regs_pkg

/* hw/sar_intf.sv */
`timescale 1ns/10ps

// ----------------------------------------------------------
// Frame descriptor link, queue to segmenter
// ----------------------------------------------------------
interface sar_frame_if;
    import sar_types_pkg::*;

    logic       valid;
    logic       ready;
    buf_id_t    buf_id;
    frame_len_t len;

    modport src (
        output valid,
        output buf_id,
        output len,
        input  ready
    );

    modport dst (
        input  valid,
        input  buf_id,
        input  len,
        output ready
    );

endinterface : sar_frame_if

// ----------------------------------------------------------
// Control link, register block to segmenter
// ----------------------------------------------------------
interface sar_ctrl_if;
    import sar_types_pkg::*;

    logic     blk_srst;
    seg_len_t seg_len;
    logic     init_done;
    // One-cycle event pulses from the segmenter
    logic     frame_done;
    logic     seg_done;

    modport regs (
        output blk_srst,
        output seg_len,
        input  init_done,
        input  frame_done,
        input  seg_done
    );

    modport core (
        input  blk_srst,
        input  seg_len,
        output init_done,
        output frame_done,
        output seg_done
    );

endinterface : sar_ctrl_if

/* hw/sar_frame_fifo.sv */
`timescale 1ns/10ps
`include "sar_cfg.svh"

module sar_frame_fifo (
    input  logic                    clk,
    input  logic                    __srst,
    input  logic                    blk_srst,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  sar_types_pkg::buf_id_t  in_buf_id,
    input  sar_types_pkg::frame_len_t in_len,
    sar_frame_if.src                out
);
    import sar_types_pkg::*;

    localparam int DEPTH = `SAR_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // Descriptor storage
    buf_id_t    mem_buf_id [DEPTH];
    frame_len_t mem_len    [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic wr_en;
    logic rd_en;
    logic full;

    assign full     = (count == CNT_W'(DEPTH));
    assign in_ready = !full && !blk_srst;
    assign wr_en    = in_valid && in_ready;
    assign rd_en    = out.valid && out.ready;

    // Head of queue straight from storage
    assign out.valid  = (count != '0);
    assign out.buf_id = mem_buf_id[rd_ptr];
    assign out.len    = mem_len[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_buf_id[wr_ptr] <= in_buf_id;
            mem_len[wr_ptr]    <= in_len;
        end
    end

    // ----------------------------------------------------------
    // Pointers and occupancy
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (__srst || blk_srst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

    // A full queue stays full until the segmenter takes an entry
    a_full_hold: assert property (@(posedge clk) disable iff (__srst || blk_srst)
        (full && !rd_en) |=> full);

    a_count_bound: assert property (@(posedge clk) disable iff (__srst)
        count <= CNT_W'(DEPTH));

endmodule : sar_frame_fifo

/* hw/sar_seg_regs.sv */
`timescale 1ns/10ps
`include "sar_cfg.svh"

module sar_seg_regs (
    input  logic                    clk,
    input  logic                    __srst,
    input  logic                    reg_wr_en,
    input  logic                    reg_rd_en,
    input  sar_regs_pkg::reg_addr_t reg_addr,
    input  sar_regs_pkg::reg_data_t reg_wr_data,
    output sar_regs_pkg::reg_data_t reg_rd_data,
    sar_ctrl_if.regs                ctrl
);
    import sar_regs_pkg::*;
    import sar_types_pkg::*;

    logic        ctrl_reset;
    seg_len_t    cfg_seg_len;
    reg_data_t   frame_count;
    reg_data_t   seg_count;
    status_reg_t status;
    info_reg_t   info;
    logic        cfg_wr_ok;

    // ----------------------------------------------------------
    // Writable registers
    // ----------------------------------------------------------

    // Zero or oversize lengths are dropped
    assign cfg_wr_ok = (reg_wr_data != '0) &&
                       (reg_wr_data <= reg_data_t'(`SAR_MAX_SEG_LEN));

    always_ff @(posedge clk) begin
        if (__srst) begin
            ctrl_reset  <= 1'b0;
            cfg_seg_len <= seg_len_t'(`SAR_DEFAULT_SEG_LEN);
        end else if (reg_wr_en) begin
            case (reg_addr_e'(reg_addr))
                CONTROL: ctrl_reset <= reg_wr_data[0];
                CONFIG: begin
                    if (cfg_wr_ok) begin
                        cfg_seg_len <= seg_len_t'(reg_wr_data);
                    end
                end
                default: ;
            endcase
        end
    end

    // Block reset, held while software keeps CONTROL bit 0 set
    always_ff @(posedge clk) begin
        ctrl.blk_srst <= __srst || ctrl_reset;
    end

    assign ctrl.seg_len = cfg_seg_len;

    // ----------------------------------------------------------
    // Counters
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (__srst || ctrl.blk_srst) begin
            frame_count <= '0;
            seg_count   <= '0;
        end else begin
            if (ctrl.frame_done) begin
                frame_count <= frame_count + 1'b1;
            end
            if (ctrl.seg_done) begin
                seg_count <= seg_count + 1'b1;
            end
        end
    end

    // ----------------------------------------------------------
    // Read path
    // ----------------------------------------------------------
    always_comb begin
        status           = '0;
        status.blk_srst  = ctrl.blk_srst;
        status.init_done = ctrl.init_done;
        info             = '0;
        info.num_buffers = 8'(`SAR_NUM_BUFFERS);
        info.max_seg_len = 16'(`SAR_MAX_SEG_LEN);
    end

    // Read data held until the next read strobe
    always_ff @(posedge clk) begin
        if (reg_rd_en) begin
            case (reg_addr_e'(reg_addr))
                CONTROL:     reg_rd_data <= reg_data_t'(ctrl_reset);
                CONFIG:      reg_rd_data <= reg_data_t'(cfg_seg_len);
                STATUS:      reg_rd_data <= reg_data_t'(status);
                INFO:        reg_rd_data <= reg_data_t'(info);
                FRAME_COUNT: reg_rd_data <= frame_count;
                SEG_COUNT:   reg_rd_data <= seg_count;
                default:     reg_rd_data <= '0;
            endcase
        end
    end

endmodule : sar_seg_regs

/* hw/sar_segmenter.sv */
`timescale 1ns/10ps
`include "sar_cfg.svh"

module sar_segmenter (
    input  logic                     clk,
    sar_frame_if.dst                 frame,
    sar_ctrl_if.core                 ctrl,
    input  logic                     seg_ready,
    output logic                     seg_valid,
    output sar_types_pkg::buf_id_t   seg_buf_id,
    output sar_types_pkg::offset_t   seg_offset,
    output sar_types_pkg::seg_len_t  seg_len,
    output logic                     seg_last
);
    import sar_types_pkg::*;

    typedef enum logic [1:0] {
        RESET,
        READY,
        PROCESSING,
        DONE
    } state_t;

    state_t state;
    state_t nxt_state;

    logic accept;
    logic seg_xfer;

    // Per-frame and per-segment context
    seg_len_t   cur_seg_len;
    frame_len_t remaining;
    offset_t    offset;
    logic       last;
    frame_len_t remaining_nxt;

    assign accept   = frame.valid && frame.ready;
    assign seg_xfer = seg_valid && seg_ready;

    // ----------------------------------------------------------
    // FSM
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (ctrl.blk_srst) begin
            state <= RESET;
        end else begin
            state <= nxt_state;
        end
    end

    always_comb begin
        nxt_state = state;
        case (state)
            RESET:      nxt_state = READY;
            READY:      if (accept) nxt_state = PROCESSING;
            PROCESSING: if (seg_xfer && last) nxt_state = DONE;
            DONE:       nxt_state = READY;
            default:    nxt_state = RESET;
        endcase
    end

    assign frame.ready     = (state == READY);
    assign seg_valid       = (state == PROCESSING);
    assign ctrl.init_done  = (state != RESET);
    assign ctrl.frame_done = accept;
    assign ctrl.seg_done   = seg_xfer;

    // ----------------------------------------------------------
    // Segment tracking
    // ----------------------------------------------------------
    assign remaining_nxt = remaining - frame_len_t'(cur_seg_len);

    // Segment length is taken from CONFIG at accept and kept for the frame
    always_ff @(posedge clk) begin
        if (accept) begin
            seg_buf_id  <= frame.buf_id;
            cur_seg_len <= ctrl.seg_len;
            remaining   <= frame.len;
            offset      <= '0;
            last        <= (frame.len <= frame_len_t'(ctrl.seg_len));
        end else if (seg_xfer) begin
            remaining <= remaining_nxt;
            offset    <= offset + offset_t'(cur_seg_len);
            last      <= (remaining_nxt <= frame_len_t'(cur_seg_len));
        end
    end

    // Final segment carries whatever is left
    assign seg_offset = offset;
    assign seg_last   = last;
    assign seg_len    = last ? seg_len_t'(remaining) : cur_seg_len;

    // ----------------------------------------------------------
    // Assertions
    // ----------------------------------------------------------
    a_frame_len: assert property (@(posedge clk) disable iff (ctrl.blk_srst)
        accept |-> (frame.len >= 1) && (frame.len <= `SAR_MAX_FRAME_SIZE));

    a_seg_stable: assert property (@(posedge clk) disable iff (ctrl.blk_srst)
        (seg_valid && !seg_ready) |=>
            seg_valid && $stable({seg_buf_id, seg_offset, seg_len, seg_last}));

    // A segment only starts on the cycle after a frame is accepted
    a_seg_after_accept: assert property (@(posedge clk) disable iff (ctrl.blk_srst)
        $rose(seg_valid) |-> $past(accept));

endmodule : sar_segmenter

/* hw/sar_seg_top.sv */
`timescale 1ns/10ps

module sar_seg_top (
    input  logic                      clk,
    input  logic                      __srst,
    // Frame descriptors in
    input  logic                      frame_valid,
    output logic                      frame_ready,
    input  sar_types_pkg::buf_id_t    frame_buf_id,
    input  sar_types_pkg::frame_len_t frame_len,
    // Segment descriptors out
    input  logic                      seg_ready,
    output logic                      seg_valid,
    output sar_types_pkg::buf_id_t    seg_buf_id,
    output sar_types_pkg::offset_t    seg_offset,
    output sar_types_pkg::seg_len_t   seg_len,
    output logic                      seg_last,
    output logic                      init_done,
    // Register strobe port
    input  logic                      reg_wr_en,
    input  logic                      reg_rd_en,
    input  sar_regs_pkg::reg_addr_t   reg_addr,
    input  sar_regs_pkg::reg_data_t   reg_wr_data,
    output sar_regs_pkg::reg_data_t   reg_rd_data
);

    sar_frame_if frame_if ();
    sar_ctrl_if  ctrl_if ();

    assign init_done = ctrl_if.init_done;

    // ----------------------------------------------------------
    // Descriptor queue
    // ----------------------------------------------------------
    sar_frame_fifo i_frame_fifo (
        .clk       ( clk ),
        .__srst    ( __srst ),
        .blk_srst  ( ctrl_if.blk_srst ),
        .in_valid  ( frame_valid ),
        .in_ready  ( frame_ready ),
        .in_buf_id ( frame_buf_id ),
        .in_len    ( frame_len ),
        .out       ( frame_if.src )
    );

    // ----------------------------------------------------------
    // Registers and block reset
    // ----------------------------------------------------------
    sar_seg_regs i_seg_regs (
        .clk         ( clk ),
        .__srst      ( __srst ),
        .reg_wr_en   ( reg_wr_en ),
        .reg_rd_en   ( reg_rd_en ),
        .reg_addr    ( reg_addr ),
        .reg_wr_data ( reg_wr_data ),
        .reg_rd_data ( reg_rd_data ),
        .ctrl        ( ctrl_if.regs )
    );

    // ----------------------------------------------------------
    // Segmenter
    // ----------------------------------------------------------
    sar_segmenter i_segmenter (
        .clk        ( clk ),
        .frame      ( frame_if.dst ),
        .ctrl       ( ctrl_if.core ),
        .seg_ready  ( seg_ready ),
        .seg_valid  ( seg_valid ),
        .seg_buf_id ( seg_buf_id ),
        .seg_offset ( seg_offset ),
        .seg_len    ( seg_len ),
        .seg_last   ( seg_last )
    );

endmodule : sar_seg_top

/* testbench/tb_sar_seg.sv */
`timescale 1ns/10ps
`include "sar_cfg.svh"

module tb_sar_seg;
    import sar_types_pkg::*;
    import sar_regs_pkg::*;

    localparam int CFG_GROUPS = 6;
    localparam int GROUP_FRAMES = 10;

    logic       clk;
    logic       __srst;
    logic       frame_valid;
    logic       frame_ready;
    buf_id_t    frame_buf_id;
    frame_len_t frame_len;
    logic       seg_ready;
    logic       seg_valid;
    buf_id_t    seg_buf_id;
    offset_t    seg_offset;
    seg_len_t   seg_len;
    logic       seg_last;
    logic       init_done;
    logic       reg_wr_en;
    logic       reg_rd_en;
    reg_addr_t  reg_addr;
    reg_data_t  reg_wr_data;
    reg_data_t  reg_rd_data;

    // Expected segment descriptor
    typedef struct packed {
        buf_id_t  buf_id;
        offset_t  offset;
        seg_len_t len;
        logic     last;
    } seg_desc_t;

    seg_desc_t exp_q[$];

    integer seed;
    int     errors;
    int     tests;
    logic   timed_out;
    int     frames_total;
    int     segs_total;
    int     cur_cfg;

    sar_seg_top UUT (
        .clk          ( clk ),
        .__srst       ( __srst ),
        .frame_valid  ( frame_valid ),
        .frame_ready  ( frame_ready ),
        .frame_buf_id ( frame_buf_id ),
        .frame_len    ( frame_len ),
        .seg_ready    ( seg_ready ),
        .seg_valid    ( seg_valid ),
        .seg_buf_id   ( seg_buf_id ),
        .seg_offset   ( seg_offset ),
        .seg_len      ( seg_len ),
        .seg_last     ( seg_last ),
        .init_done    ( init_done ),
        .reg_wr_en    ( reg_wr_en ),
        .reg_rd_en    ( reg_rd_en ),
        .reg_addr     ( reg_addr ),
        .reg_wr_data  ( reg_wr_data ),
        .reg_rd_data  ( reg_rd_data )
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // ----------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------
    function automatic int rand_between(int lo, int hi);
        int r;
        r = $random(seed);
        r = r & 32'h7fff_ffff;
        return lo + (r % (hi - lo + 1));
    endfunction

    task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s actual=%0d expected=%0d",
                     $time, name, actual, expected);
            errors++;
        end
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic reg_write(reg_addr_e addr, reg_data_t data);
        reg_wr_en   = 1'b1;
        reg_addr    = addr;
        reg_wr_data = data;
        next_cycle();
        reg_wr_en = 1'b0;
    endtask

    // Read data is registered on the strobe edge
    task automatic reg_read(reg_addr_e addr, output reg_data_t data);
        reg_rd_en = 1'b1;
        reg_addr  = addr;
        next_cycle();
        reg_rd_en = 1'b0;
        data      = reg_rd_data;
    endtask

    task automatic expect_reg(reg_addr_e addr, reg_data_t expected, string name);
        reg_data_t data;
        reg_read(addr, data);
        check_value(name, data, expected);
    endtask

    task automatic flag_timeout(string what);
        $display("TIMEOUT at %0t ns: %s", $time, what);
        timed_out = 1'b1;
        errors++;
    endtask

    // ----------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------
    task automatic add_frame_to_model(buf_id_t id, frame_len_t len);
        seg_desc_t d;
        int        rem;
        int        off;
        rem = len;
        off = 0;
        while (rem > 0) begin
            d.buf_id = id;
            d.offset = offset_t'(off);
            d.last   = (rem <= cur_cfg);
            d.len    = d.last ? seg_len_t'(rem) : seg_len_t'(cur_cfg);
            exp_q.push_back(d);
            segs_total++;
            rem -= cur_cfg;
            off += cur_cfg;
        end
        frames_total++;
    endtask

    task automatic check_segment();
        seg_desc_t d;
        if (exp_q.size() == 0) begin
            $display("ERROR at %0t ns: segment handed out while none was expected", $time);
            errors++;
        end else begin
            d = exp_q.pop_front();
            check_value("seg_buf_id", seg_buf_id, d.buf_id);
            check_value("seg_offset", seg_offset, d.offset);
            check_value("seg_len", seg_len, d.len);
            check_value("seg_last", seg_last, d.last);
        end
    endtask

    task automatic load_frame();
        frame_buf_id = buf_id_t'(rand_between(0, `SAR_NUM_BUFFERS - 1));
        frame_len    = frame_len_t'(rand_between(1, `SAR_MAX_FRAME_SIZE));
    endtask

    // ----------------------------------------------------------
    // Traffic
    // ----------------------------------------------------------

    // Offer n frames and consume segments until the model is empty
    task automatic run_frames(int n);
        int   sent;
        int   quiet;
        logic take;
        logic seg_hs;
        sent  = 0;
        quiet = 0;
        frame_valid = 1'b0;
        if (n > 0) begin
            frame_valid = 1'b1;
            load_frame();
        end
        while ((sent < n || exp_q.size() != 0) && !timed_out) begin
            seg_ready = (rand_between(0, 99) < 70);
            #1;
            take   = frame_valid && frame_ready;
            seg_hs = seg_valid && seg_ready;
            if (take) begin
                add_frame_to_model(frame_buf_id, frame_len);
                sent++;
            end
            if (seg_hs) begin
                check_segment();
            end
            if (take || seg_hs) begin
                quiet = 0;
            end else begin
                quiet++;
            end
            if (quiet > 2000) begin
                flag_timeout("no frame or segment handshake for 2000 cycles");
            end
            next_cycle();
            if (take) begin
                if (sent < n) begin
                    load_frame();
                end else begin
                    frame_valid = 1'b0;
                end
            end
        end
        frame_valid = 1'b0;
        seg_ready   = 1'b0;
    endtask

    // Stalled output, frames offered until frame_ready stays low
    task automatic fill_under_stall(output int accepted);
        int   low_run;
        int   cycles;
        logic take;
        accepted    = 0;
        low_run     = 0;
        cycles      = 0;
        seg_ready   = 1'b0;
        frame_valid = 1'b1;
        load_frame();
        while (low_run < 8 && !timed_out) begin
            #1;
            take = frame_ready;
            if (take) begin
                add_frame_to_model(frame_buf_id, frame_len);
                accepted++;
                low_run = 0;
            end else begin
                low_run++;
            end
            cycles++;
            if (cycles > 200) begin
                flag_timeout("frame_ready never stayed low with segments stalled");
            end
            next_cycle();
            if (take) begin
                load_frame();
            end
        end
        frame_valid = 1'b0;
    endtask

    task automatic wait_init_done(logic level, string what);
        int cycles;
        cycles = 0;
        while (init_done !== level && !timed_out) begin
            if (cycles >= 50) begin
                flag_timeout(what);
            end else begin
                next_cycle();
                cycles++;
            end
        end
    endtask

    task automatic report_test(string name, int err_mark);
        tests++;
        if (errors == err_mark) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d errors", tests, name, errors - err_mark);
        end
    endtask

    // ----------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------
    initial begin
        int err_mark;
        int accepted;
        seed         = 32'hc128_4086;
        errors       = 0;
        tests        = 0;
        timed_out    = 1'b0;
        frames_total = 0;
        segs_total   = 0;
        cur_cfg      = `SAR_DEFAULT_SEG_LEN;
        __srst       = 1'b1;
        frame_valid  = 1'b0;
        frame_buf_id = '0;
        frame_len    = '0;
        seg_ready    = 1'b0;
        reg_wr_en    = 1'b0;
        reg_rd_en    = 1'b0;
        reg_addr     = '0;
        reg_wr_data  = '0;
        repeat (3) @(posedge clk);
        #1;
        __srst = 1'b0;

        // Register defaults and read-back
        err_mark = errors;
        check_value("init_done", init_done, 0);
        wait_init_done(1'b1, "init_done did not rise after reset");
        expect_reg(STATUS, 32'd2, "STATUS");
        expect_reg(CONFIG, `SAR_DEFAULT_SEG_LEN, "CONFIG");
        expect_reg(INFO, (`SAR_MAX_SEG_LEN << 16) | `SAR_NUM_BUFFERS, "INFO");
        reg_write(CONFIG, 32'd100);
        expect_reg(CONFIG, 32'd100, "CONFIG");
        reg_write(CONFIG, 32'd0);
        expect_reg(CONFIG, 32'd100, "CONFIG");
        reg_write(CONFIG, 32'd2000);
        expect_reg(CONFIG, 32'd100, "CONFIG");
        cur_cfg = 100;
        report_test("register defaults", err_mark);

        // Random frames, new segment length per group
        if (!timed_out) begin
            err_mark = errors;
            for (int g = 0; g < CFG_GROUPS && !timed_out; g++) begin
                cur_cfg = rand_between(1, `SAR_MAX_SEG_LEN);
                reg_write(CONFIG, reg_data_t'(cur_cfg));
                run_frames(GROUP_FRAMES);
            end
            report_test("segmentation under back-pressure", err_mark);
        end

        if (!timed_out) begin
            err_mark = errors;
            expect_reg(FRAME_COUNT, frames_total, "FRAME_COUNT");
            expect_reg(SEG_COUNT, segs_total, "SEG_COUNT");
            report_test("frame counting", err_mark);
        end

        if (!timed_out) begin
            err_mark = errors;
            fill_under_stall(accepted);
            check_value("frames accepted under stall", accepted, `SAR_FIFO_DEPTH + 1);
            run_frames(0);
            report_test("queue fill under stall", err_mark);
        end

        // Block reset with frames still queued
        if (!timed_out) begin
            err_mark = errors;
            fill_under_stall(accepted);
            reg_write(CONTROL, 32'd1);
            wait_init_done(1'b0, "init_done did not fall after block reset");
            check_value("frame_ready", frame_ready, 0);
            check_value("seg_valid", seg_valid, 0);
            expect_reg(STATUS, 32'd1, "STATUS");
            expect_reg(FRAME_COUNT, 32'd0, "FRAME_COUNT");
            expect_reg(SEG_COUNT, 32'd0, "SEG_COUNT");
            exp_q.delete();
            frames_total = 0;
            segs_total   = 0;
            reg_write(CONTROL, 32'd0);
            wait_init_done(1'b1, "init_done did not return after block reset");
            expect_reg(CONFIG, cur_cfg, "CONFIG");
            run_frames(8);
            expect_reg(FRAME_COUNT, frames_total, "FRAME_COUNT");
            expect_reg(SEG_COUNT, segs_total, "SEG_COUNT");
            report_test("block reset through CONTROL", err_mark);
        end

        $display("tests: %0d, errors: %0d", tests, errors);
        if (errors == 0 && !timed_out) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule : tb_sar_seg

/* sar_seg.f */
+incdir+include
hw/sar_types_pkg.sv
hw/sar_regs_pkg.sv
hw/sar_intf.sv
hw/sar_frame_fifo.sv
hw/sar_seg_regs.sv
hw/sar_segmenter.sv
hw/sar_seg_top.sv
testbench/tb_sar_seg.sv

/* run_sar_seg.sh */
#!/bin/sh
# Build and run the segmentation engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_sar_seg -f sar_seg.f -o sim_sar_seg
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_sar_seg)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q '^STATUS: PASS$'; then
    exit 0
fi
exit 1
